// File: hw/app_soc_settings.svh
/*
 * Application subsystem settings
 * Memory sizes and address map field positions
 */

`ifndef APP_SOC_SETTINGS_SVH
`define APP_SOC_SETTINGS_SVH

// Memory sizes in words
`define APP_ROM_ADDR_BITS 8
`define APP_ROM_DEPTH     (1 << `APP_ROM_ADDR_BITS)
`define APP_RAM_ADDR_BITS 10
`define APP_RAM_DEPTH     (1 << `APP_RAM_ADDR_BITS)

// Address map fields
`define APP_AREA_MSB      31
`define APP_AREA_LSB      30
`define APP_CORE_MSB      29
`define APP_CORE_LSB      24
`define APP_WORD_LSB      2
`define APP_REG_ADDR_BITS 8

// Upper half of every ROM word
`define APP_ROM_TAG       16'hC0DE

`endif

// File: hw/app_bus_pkg.sv
/*
 * Bus transfer types
 * Master request, decoder response and per-target bundles
 */

`include "app_soc_settings.svh"

`default_nettype none

package app_bus_pkg;

  // Request as issued by the bus master
  typedef struct packed {
    logic        valid;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // Registered response back to the master
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } bus_rsp_t;

  // What one target sees, word address only
  typedef struct packed {
    logic                          cs;
    logic [3:0]                    we;
    logic [`APP_RAM_ADDR_BITS-1:0] addr;
    logic [31:0]                   wdata;
  } tgt_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] read_data;
  } tgt_rsp_t;

endpackage

`default_nettype wire

// File: hw/app_map_pkg.sv
/*
 * Address map and state encodings
 */

`include "app_soc_settings.svh"

`default_nettype none

package app_map_pkg;

  // Top level areas, address bits 31:30
  typedef enum logic [1:0] {
    AREA_ROM      = 2'd0,
    AREA_RAM      = 2'd1,
    AREA_RESERVED = 2'd2,
    AREA_MMIO     = 2'd3
  } area_e;

  // MMIO cores, address bits 29:24
  typedef enum logic [5:0] {
    CORE_TIMER = 6'h01,
    CORE_TOUCH = 6'h04
  } core_e;

  typedef enum logic [`APP_REG_ADDR_BITS-1:0] {
    TMR_CTRL      = 'd0,
    TMR_STATUS    = 'd1,
    TMR_PRESCALER = 'd2,
    TMR_VALUE     = 'd3
  } timer_reg_e;

  typedef enum logic [1:0] {
    TOUCH_IDLE,
    TOUCH_LATCHED,
    TOUCH_WAIT_RELEASE
  } touch_state_e;

endpackage

`default_nettype wire

// File: hw/app_bus_decoder.sv
/*
 * Bus decoder
 * Steers master transfers to ROM, RAM or an MMIO core and registers the reply
 */

`include "app_soc_settings.svh"

`default_nettype none

module app_bus_decoder
  import app_bus_pkg::*;
  import app_map_pkg::*;
(
  input  wire           clk,
  input  wire           reset_n,
  input  wire bus_req_t bus_req,
  output bus_rsp_t      bus_rsp,
  output tgt_req_t      rom_req,
  output tgt_req_t      ram_req,
  output tgt_req_t      timer_req,
  output tgt_req_t      touch_req,
  input  wire tgt_rsp_t rom_rsp,
  input  wire tgt_rsp_t ram_rsp,
  input  wire tgt_rsp_t timer_rsp,
  input  wire tgt_rsp_t touch_rsp
);

  localparam int unsigned WORD_MSB = `APP_RAM_ADDR_BITS + `APP_WORD_LSB - 1;

  area_e                area_prefix;
  logic [$bits(core_e)-1:0] core_prefix;
  tgt_req_t             base_req;
  bus_rsp_t             rsp_d;
  bus_rsp_t             rsp_q;

  assign area_prefix = area_e'(bus_req.addr[`APP_AREA_MSB:`APP_AREA_LSB]);
  assign core_prefix = bus_req.addr[`APP_CORE_MSB:`APP_CORE_LSB];

  // Common part of every target request, cs is added per target
  always_comb begin
    base_req.cs    = 1'b0;
    base_req.we    = bus_req.wstrb;
    base_req.addr  = bus_req.addr[WORD_MSB:`APP_WORD_LSB];
    base_req.wdata = bus_req.wdata;
  end

  // --------------------------------------------------
  // Target select and response mux
  // --------------------------------------------------
  always_comb begin : decode
    rom_req   = base_req;
    ram_req   = base_req;
    timer_req = base_req;
    touch_req = base_req;
    rsp_d     = '0;

    // No select while ready is out, so a held valid completes once
    if (bus_req.valid && !rsp_q.ready) begin
      case (area_prefix)
        AREA_ROM: begin
          rom_req.cs  = 1'b1;
          rsp_d.ready = rom_rsp.ready;
          rsp_d.rdata = rom_rsp.read_data;
        end
        AREA_RAM: begin
          ram_req.cs  = 1'b1;
          rsp_d.ready = ram_rsp.ready;
          rsp_d.rdata = ram_rsp.read_data;
        end
        AREA_MMIO: begin
          case (core_prefix)
            CORE_TIMER: begin
              timer_req.cs = 1'b1;
              rsp_d.ready  = timer_rsp.ready;
              rsp_d.rdata  = timer_rsp.read_data;
            end
            CORE_TOUCH: begin
              touch_req.cs = 1'b1;
              rsp_d.ready  = touch_rsp.ready;
              rsp_d.rdata  = touch_rsp.read_data;
            end
            // Undefined core completes with zero
            default: rsp_d.ready = 1'b1;
          endcase
        end
        // Reserved area completes with zero
        default: rsp_d.ready = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_d;
    end
  end

  assign bus_rsp = rsp_q;

endmodule

`default_nettype wire

// File: hw/app_rom.sv
/*
 * Fixed-pattern ROM
 * Word i reads as the ROM tag joined with i
 */

`include "app_soc_settings.svh"

`default_nettype none

module app_rom
  import app_bus_pkg::*;
(
  input  wire tgt_req_t req,
  output tgt_rsp_t      rsp
);

  logic [31:0]                   rom_words [`APP_ROM_DEPTH];
  logic [`APP_ROM_ADDR_BITS-1:0] word_addr;

  // Contents
  for (genvar i = 0; i < `APP_ROM_DEPTH; i++) begin : g_word
    assign rom_words[i] = {`APP_ROM_TAG, 16'(i)};
  end

  // ROM only looks at the low word address bits
  assign word_addr = req.addr[`APP_ROM_ADDR_BITS-1:0];

  // Writes land nowhere but complete like reads
  assign rsp.ready     = req.cs;
  assign rsp.read_data = rom_words[word_addr];

endmodule

`default_nettype wire

// File: hw/app_ram.sv
/*
 * Word RAM with byte write strobes
 * Read data and ready follow chip select by one cycle
 */

`include "app_soc_settings.svh"

`default_nettype none

module app_ram
  import app_bus_pkg::*;
(
  input  wire           clk,
  input  wire           reset_n,
  input  wire tgt_req_t req,
  output tgt_rsp_t      rsp
);

  logic [31:0] mem [`APP_RAM_DEPTH];
  logic [31:0] read_data_q;
  logic        ready_q;
  logic        access;

  // One access per request, the cycle with ready high is idle
  assign access = req.cs && !ready_q;

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (access) begin
      for (int b = 0; b < 4; b++) begin
        if (req.we[b]) begin
          mem[req.addr][b*8 +: 8] <= req.wdata[b*8 +: 8];
        end
      end
      read_data_q <= mem[req.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  assign rsp.ready     = ready_q;
  assign rsp.read_data = read_data_q;

endmodule

`default_nettype wire

// File: hw/app_timer.sv
/*
 * Down-counting timer with prescaler
 * Stops by itself when the value reaches zero
 */

`include "app_soc_settings.svh"

`default_nettype none

module app_timer
  import app_bus_pkg::*;
  import app_map_pkg::*;
(
  input  wire           clk,
  input  wire           reset_n,
  input  wire tgt_req_t req,
  output tgt_rsp_t      rsp
);

  timer_reg_e  reg_sel;
  logic        wr;
  logic        running;
  logic [31:0] prescaler;
  logic [31:0] value;
  logic [31:0] presc_cnt;

  assign reg_sel = timer_reg_e'(req.addr[`APP_REG_ADDR_BITS-1:0]);
  assign wr      = req.cs && (|req.we);

  // --------------------------------------------------
  // Control and count
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      running   <= 1'b0;
      prescaler <= '0;
      value     <= '0;
      presc_cnt <= '0;
    end else if (wr && reg_sel == TMR_CTRL) begin
      running   <= req.wdata[0];
      presc_cnt <= '0;
    end else if (running) begin
      if (value == '0) begin
        running <= 1'b0;
      end else if (presc_cnt == prescaler) begin
        presc_cnt <= '0;
        value     <= value - 1'b1;
        running   <= (value != 32'd1);
      end else begin
        presc_cnt <= presc_cnt + 1'b1;
      end
    end else if (wr && reg_sel == TMR_PRESCALER) begin
      prescaler <= req.wdata;
    end else if (wr && reg_sel == TMR_VALUE) begin
      value <= req.wdata;
    end
  end

  always_comb begin
    case (reg_sel)
      TMR_CTRL, TMR_STATUS: rsp.read_data = {31'b0, running};
      TMR_PRESCALER:        rsp.read_data = prescaler;
      TMR_VALUE:            rsp.read_data = value;
      default:              rsp.read_data = '0;
    endcase
  end

  assign rsp.ready = req.cs;

endmodule

`default_nettype wire

// File: hw/app_touch_sense.sv
/*
 * Touch sense core
 * Latches a touch event until software clears it with a write
 */

`include "app_soc_settings.svh"

`default_nettype none

module app_touch_sense
  import app_bus_pkg::*;
  import app_map_pkg::*;
(
  input  wire           clk,
  input  wire           reset_n,
  input  wire logic     touch_event,
  input  wire tgt_req_t req,
  output tgt_rsp_t      rsp
);

  logic [1:0]   sync_q;
  logic         touch_prev;
  touch_state_e state;
  logic         wr;

  assign wr = req.cs && (|req.we);

  // Two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sync_q     <= '0;
      touch_prev <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], touch_event};
      touch_prev <= sync_q[1];
    end
  end

  // --------------------------------------------------
  // Event FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= TOUCH_IDLE;
    end else if (wr) begin
      state <= TOUCH_WAIT_RELEASE;
    end else begin
      case (state)
        TOUCH_IDLE: if (sync_q[1] && !touch_prev) state <= TOUCH_LATCHED;
        TOUCH_WAIT_RELEASE: if (!sync_q[1]) state <= TOUCH_IDLE;
        default: state <= state;
      endcase
    end
  end

  // Status register at offset 0
  assign rsp.read_data = (req.addr[`APP_REG_ADDR_BITS-1:0] == '0) ?
                         {31'b0, state == TOUCH_LATCHED} : '0;
  assign rsp.ready     = req.cs;

endmodule

`default_nettype wire

// File: hw/app_soc.sv
/*
 * Application subsystem top level
 * Bus decoder with ROM, RAM, timer and touch sense targets
 */

`default_nettype none

module app_soc
  import app_bus_pkg::*;
(
  input  wire           clk,
  input  wire           reset_n,
  input  wire bus_req_t bus_req,
  output bus_rsp_t      bus_rsp,
  input  wire logic     touch_event
);

  tgt_req_t rom_req;
  tgt_req_t ram_req;
  tgt_req_t timer_req;
  tgt_req_t touch_req;
  tgt_rsp_t rom_rsp;
  tgt_rsp_t ram_rsp;
  tgt_rsp_t timer_rsp;
  tgt_rsp_t touch_rsp;

  // --------------------------------------------------
  // Decoder and targets
  // --------------------------------------------------
  app_bus_decoder decoder0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .rom_req   (rom_req),
    .ram_req   (ram_req),
    .timer_req (timer_req),
    .touch_req (touch_req),
    .rom_rsp   (rom_rsp),
    .ram_rsp   (ram_rsp),
    .timer_rsp (timer_rsp),
    .touch_rsp (touch_rsp)
  );

  app_rom rom0 (
    .req (rom_req),
    .rsp (rom_rsp)
  );

  app_ram ram0 (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (ram_req),
    .rsp     (ram_rsp)
  );

  app_timer timer0 (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (timer_req),
    .rsp     (timer_rsp)
  );

  app_touch_sense touch0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .touch_event (touch_event),
    .req         (touch_req),
    .rsp         (touch_rsp)
  );

endmodule

`default_nettype wire

// File: testbench/app_soc_chk.sv
/*
 * Decoder handshake checker
 * Concurrent assertions on ready and the target selects
 */

`default_nettype none

module app_soc_chk
  import app_bus_pkg::*;
(
  input wire           clk,
  input wire           reset_n,
  input wire bus_req_t bus_req,
  input wire bus_rsp_t bus_rsp,
  input wire tgt_req_t rom_req,
  input wire tgt_req_t ram_req,
  input wire tgt_req_t timer_req,
  input wire tgt_req_t touch_req
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failure count, read by the testbench at the end of the run
  int fail_count = 0;

  ready_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
      bus_rsp.ready |=> !bus_rsp.ready)
    else begin
      fail_count++;
      $error("bus ready stayed high for two cycles");
    end

  ready_after_valid: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(bus_rsp.ready) |-> $past(bus_req.valid))
    else begin
      fail_count++;
      $error("bus ready rose without valid in the previous cycle");
    end

  one_target: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0({rom_req.cs, ram_req.cs, timer_req.cs, touch_req.cs}))
    else begin
      fail_count++;
      $error("more than one target selected");
    end

  // Ready comes out of reset low
  ready_low_after_reset: assert property (@(posedge clk)
      !reset_n |=> !bus_rsp.ready)
    else begin
      fail_count++;
      $error("bus ready high in the cycle after reset");
    end

endmodule

bind app_bus_decoder app_soc_chk chk0 (
  .clk       (clk),
  .reset_n   (reset_n),
  .bus_req   (bus_req),
  .bus_rsp   (bus_rsp),
  .rom_req   (rom_req),
  .ram_req   (ram_req),
  .timer_req (timer_req),
  .touch_req (touch_req)
);

`default_nettype wire

// File: testbench/app_soc_tb.sv
/*
 * Testbench for the application subsystem
 * Drives the master bus directly and checks every target
 */

`include "app_soc_settings.svh"

`default_nettype none

module app_soc_tb
  import app_bus_pkg::*;
  import app_map_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int EST_TEST_CYCLES = 1500;
  localparam int TIMEOUT_CYCLES  = 3 * EST_TEST_CYCLES + 500;
  localparam int RAM_WRITES      = 24;

  logic        clk;
  logic        reset_n;
  logic        touch_event;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  int          cycle_count;
  int          check_count;
  int          error_count;
  logic [31:0] lcg_state;
  logic [31:0] ram_model [`APP_RAM_DEPTH];

  app_soc dut0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp),
    .touch_event (touch_event)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] mem_addr(area_e area, int unsigned word);
    return (32'(area) << `APP_AREA_LSB) | (32'(word) << `APP_WORD_LSB);
  endfunction

  function automatic logic [31:0] mmio_addr(logic [5:0] core, int unsigned offset);
    return (32'(AREA_MMIO) << `APP_AREA_LSB) | (32'(core) << `APP_CORE_LSB) |
           (32'(offset) << `APP_WORD_LSB);
  endfunction

  // Called 1 ns after a rising edge, returns at the same phase
  task automatic bus_transfer(input logic [31:0] addr, input logic [3:0] wstrb,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    bus_req.valid = 1'b1;
    bus_req.wstrb = wstrb;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    do begin
      @(posedge clk);
      #1;
    end while (!bus_rsp.ready);
    rdata = bus_rsp.rdata;
    // Valid stays up through the ready cycle and drops in the next one
    @(posedge clk);
    #1;
    bus_req = '0;
    // Idle cycle after the drop
    @(posedge clk);
    #1;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] wstrb,
                           input logic [31:0] wdata);
    logic [31:0] unused;
    bus_transfer(addr, wstrb, wdata, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_transfer(addr, 4'h0, 32'h0, rdata);
  endtask

  task automatic poll_read(input logic [31:0] addr, input logic [31:0] target,
                           input int max_reads, output logic [31:0] rdata);
    int n;
    n = 0;
    do begin
      bus_read(addr, rdata);
      n++;
    end while (rdata !== target && n < max_reads);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    value_match: assert (got === expected) else begin
      error_count++;
      $display("FAIL bus_rsp.rdata (%s): got 0x%h expected 0x%h", what, got, expected);
    end
  endtask

  // --------------------------------------------------
  // Behaviors
  // --------------------------------------------------
  task automatic read_rom_words();
    int unsigned words [$] = '{0, 1, 7, 8'h55, 8'hAA, 8'hFF};
    logic [31:0] rd;
    foreach (words[i]) begin
      bus_read(mem_addr(AREA_ROM, words[i]), rd);
      check_value("ROM word", rd, {`APP_ROM_TAG, 16'(words[i])});
    end
    // Writes leave the ROM unchanged
    bus_write(mem_addr(AREA_ROM, 3), 4'hF, 32'h1234_5678);
    bus_read(mem_addr(AREA_ROM, 3), rd);
    check_value("ROM word after write", rd, {`APP_ROM_TAG, 16'd3});
  endtask

  task automatic ram_write_readback();
    logic [3:0]  strobes [3] = '{4'b0101, 4'b1000, 4'b0110};
    int unsigned written [$];
    int unsigned word;
    logic [31:0] rd;
    logic [31:0] wr_data;
    logic [31:0] merged;
    for (int i = 0; i < RAM_WRITES; i++) begin
      word    = (lcg_next() >> 8) % `APP_RAM_DEPTH;
      wr_data = lcg_next();
      bus_write(mem_addr(AREA_RAM, word), 4'hF, wr_data);
      ram_model[word] = wr_data;
      written.push_back(word);
    end
    foreach (written[i]) begin
      bus_read(mem_addr(AREA_RAM, written[i]), rd);
      check_value("RAM word", rd, ram_model[written[i]]);
    end
    // Partial writes keep the bytes whose strobe is clear
    foreach (strobes[k]) begin
      word    = written[k];
      wr_data = lcg_next();
      merged  = ram_model[word];
      for (int b = 0; b < 4; b++) begin
        if (strobes[k][b]) begin
          merged[b*8 +: 8] = wr_data[b*8 +: 8];
        end
      end
      bus_write(mem_addr(AREA_RAM, word), strobes[k], wr_data);
      ram_model[word] = merged;
      bus_read(mem_addr(AREA_RAM, word), rd);
      check_value("RAM partial write", rd, merged);
    end
  endtask

  task automatic access_unmapped();
    logic [31:0] rd;
    bus_read(mem_addr(AREA_RESERVED, 16), rd);
    check_value("reserved area", rd, 32'h0);
    bus_read(mmio_addr(6'h20, 0), rd);
    check_value("undefined core", rd, 32'h0);
    bus_write(mem_addr(AREA_RESERVED, 16), 4'hF, 32'hDEAD_BEEF);
    bus_write(mmio_addr(6'h20, 0), 4'hF, 32'hDEAD_BEEF);
    bus_read(mmio_addr(6'h20, 0), rd);
    check_value("undefined core after write", rd, 32'h0);
  endtask

  task automatic run_timer();
    logic [31:0] rd;
    bus_write(mmio_addr(CORE_TIMER, TMR_VALUE), 4'hF, 32'd20);
    bus_write(mmio_addr(CORE_TIMER, TMR_PRESCALER), 4'hF, 32'd2);
    bus_read(mmio_addr(CORE_TIMER, TMR_PRESCALER), rd);
    check_value("timer prescaler", rd, 32'd2);
    bus_write(mmio_addr(CORE_TIMER, TMR_CTRL), 4'hF, 32'd1);
    bus_read(mmio_addr(CORE_TIMER, TMR_STATUS), rd);
    check_value("timer status running", rd, 32'd1);
    poll_read(mmio_addr(CORE_TIMER, TMR_STATUS), 32'd0, 100, rd);
    check_value("timer status stopped", rd, 32'd0);
    bus_read(mmio_addr(CORE_TIMER, TMR_VALUE), rd);
    check_value("timer value at end", rd, 32'd0);

    // Value is locked while running
    bus_write(mmio_addr(CORE_TIMER, TMR_VALUE), 4'hF, 32'd20);
    bus_write(mmio_addr(CORE_TIMER, TMR_CTRL), 4'hF, 32'd1);
    bus_write(mmio_addr(CORE_TIMER, TMR_VALUE), 4'hF, 32'd1000);
    bus_read(mmio_addr(CORE_TIMER, TMR_VALUE), rd);
    check_count++;
    value_locked: assert (rd <= 32'd20) else begin
      error_count++;
      $display("FAIL bus_rsp.rdata (timer value): got 0x%h expected at most 0x%h", rd, 32'd20);
    end
    poll_read(mmio_addr(CORE_TIMER, TMR_STATUS), 32'd0, 100, rd);
    check_value("timer status stopped again", rd, 32'd0);
  endtask

  task automatic sense_touch();
    logic [31:0] rd;
    bus_read(mmio_addr(CORE_TOUCH, 0), rd);
    check_value("touch status idle", rd, 32'd0);
    for (int pulse = 0; pulse < 2; pulse++) begin
      touch_event = 1'b1;
      poll_read(mmio_addr(CORE_TOUCH, 0), 32'd1, 20, rd);
      check_value("touch status latched", rd, 32'd1);
      touch_event = 1'b0;
      repeat (4) begin
        bus_read(mmio_addr(CORE_TOUCH, 0), rd);
        check_value("touch status after release", rd, 32'd1);
      end
      // Software clear
      bus_write(mmio_addr(CORE_TOUCH, 0), 4'hF, 32'h0);
      bus_read(mmio_addr(CORE_TOUCH, 0), rd);
      check_value("touch status cleared", rd, 32'd0);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    reset_n     = 1'b0;
    touch_event = 1'b0;
    bus_req     = '0;
    lcg_state   = 32'd95;
    check_count = 0;
    error_count = 0;
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(posedge clk);
    #1;

    read_rom_words();
    ram_write_readback();
    access_unmapped();
    run_timer();
    sense_touch();

    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             check_count, error_count, dut0.decoder0.chk0.fail_count);
    if (error_count == 0 && dut0.decoder0.chk0.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: app_soc.f
+incdir+hw
hw/app_bus_pkg.sv
hw/app_map_pkg.sv
hw/app_bus_decoder.sv
hw/app_rom.sv
hw/app_ram.sv
hw/app_timer.sv
hw/app_touch_sense.sv
hw/app_soc.sv
testbench/app_soc_chk.sv
testbench/app_soc_tb.sv

// File: Bender.yml
package:
  name: app_soc

sources:
  - include_dirs:
      - hw
    files:
      - hw/app_bus_pkg.sv
      - hw/app_map_pkg.sv
      - hw/app_bus_decoder.sv
      - hw/app_rom.sv
      - hw/app_ram.sv
      - hw/app_timer.sv
      - hw/app_touch_sense.sv
      - hw/app_soc.sv
      - target: test
        files:
          - testbench/app_soc_chk.sv
          - testbench/app_soc_tb.sv
